// File: common/rvIsaPkg.sv
package rvIsaPkg;

  localparam int xlen        = 32;
  localparam int regAddrBits = 5;
  localparam int numRegs     = 32;

  typedef logic [xlen-1:0]        word_t;
  typedef logic [regAddrBits-1:0] regAddr_t;

  // Major opcodes in use, custom-0 carries RVX10
  typedef enum logic [6:0] {
    opLoad    = 7'b0000011,
    opStore   = 7'b0100011,
    opRtype   = 7'b0110011,
    opBranch  = 7'b1100011,
    opItype   = 7'b0010011,
    opJal     = 7'b1101111,
    opCustom0 = 7'b0001011
  } opcode_e;

  typedef enum logic [1:0] {immI, immS, immB, immJ} immKind_e;

  // Base funct3 codes
  localparam logic [2:0] f3AddSub = 3'b000;
  localparam logic [2:0] f3Slt    = 3'b010;
  localparam logic [2:0] f3Or     = 3'b110;
  localparam logic [2:0] f3And    = 3'b111;
  localparam logic [2:0] f3Word   = 3'b010;  // lw and sw
  localparam logic [2:0] f3Beq    = 3'b000;

  // RVX10 groups by funct7
  localparam logic [6:0] f7Logic  = 7'b0000000;
  localparam logic [6:0] f7MinMax = 7'b0000001;
  localparam logic [6:0] f7Rotate = 7'b0000010;
  localparam logic [6:0] f7Abs    = 7'b0000011;

  // RVX10 funct3 inside each group
  localparam logic [2:0] f3Andn = 3'b000;
  localparam logic [2:0] f3Orn  = 3'b001;
  localparam logic [2:0] f3Xnor = 3'b010;
  localparam logic [2:0] f3Min  = 3'b000;
  localparam logic [2:0] f3Max  = 3'b001;
  localparam logic [2:0] f3Minu = 3'b010;
  localparam logic [2:0] f3Maxu = 3'b011;
  localparam logic [2:0] f3Rol  = 3'b000;
  localparam logic [2:0] f3Ror  = 3'b001;
  localparam logic [2:0] f3Abs  = 3'b000;

endpackage

// File: common/pipeCtrlPkg.sv
package pipeCtrlPkg;

  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt,
    aluRol,
    aluRor,
    aluAndn,
    aluOrn,
    aluXnor,
    aluMin,
    aluMax,
    aluMinu,
    aluMaxu,
    aluAbs
  } aluOp_e;

  typedef enum logic [1:0] {resAlu, resMem, resPcPlus4} resultSel_e;

  // Source of an execute operand
  typedef enum logic [1:0] {fwdNone, fwdWb, fwdMem} fwdSel_e;

  // Decoded control, all zero is a bubble
  typedef struct packed {
    logic       regWrite;
    resultSel_e resultSel;
    logic       memWrite;
    logic       jump;
    logic       branch;
    aluOp_e     aluOp;
    logic       aluSrc;
  } ctrlWord_t;

endpackage

// File: common/ctrlIf.sv
`timescale 1ns/1ps

interface ctrlIf;
  import rvIsaPkg::*;
  import pipeCtrlPkg::*;

  word_t      instrD;
  logic       zeroE;
  immKind_e   immSrcD;
  aluOp_e     aluOpE;
  logic       aluSrcE;     // Immediate as operand B
  logic       regWriteW;
  resultSel_e resultSelW;

  modport dp (
    output instrD, zeroE,
    input  immSrcD, aluOpE, aluSrcE, regWriteW, resultSelW
  );
  modport ctrl (
    input  instrD, zeroE,
    output immSrcD, aluOpE, aluSrcE, regWriteW, resultSelW
  );
endinterface

// File: common/hazardIf.sv
`timescale 1ns/1ps

interface hazardIf (
  input logic clk,
  input logic reset
);
  import rvIsaPkg::*;
  import pipeCtrlPkg::*;

  regAddr_t rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW;
  logic     regWriteM, regWriteW;
  logic     loadE;   // Execute holds a load
  logic     pcSrcE;
  logic     stallF, stallD, flushD, flushE;
  fwdSel_e  forwardA, forwardB;

  modport dp (
    output rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW,
    input  stallF, stallD, flushD, flushE, forwardA, forwardB, pcSrcE
  );
  modport ctrl (
    output regWriteM, regWriteW, loadE, pcSrcE,
    input  flushE
  );
  modport haz (
    input  clk, reset, rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW,
    input  regWriteM, regWriteW, loadE, pcSrcE,
    output stallF, stallD, flushD, flushE, forwardA, forwardB
  );
endinterface

// File: datapath/regFile.sv
`timescale 1ns/1ps

module regFile (
  input  logic              clk,
  input  logic              reset,
  input  rvIsaPkg::regAddr_t rs1,
  input  rvIsaPkg::regAddr_t rs2,
  input  rvIsaPkg::regAddr_t rd,
  input  logic              we,
  input  rvIsaPkg::word_t   wd,
  output rvIsaPkg::word_t   rd1,
  output rvIsaPkg::word_t   rd2
);
  import rvIsaPkg::*;

  word_t [numRegs-1:0] regs;

  // Falling edge write, decode reads the new value in the same cycle
  always_ff @(negedge clk or posedge reset) begin
    if (reset) regs <= '0;
    else if (we && rd != '0) regs[rd] <= wd;
  end

  assign rd1 = (rs1 != '0) ? regs[rs1] : '0;
  assign rd2 = (rs2 != '0) ? regs[rs2] : '0;

  assert property (@(negedge clk) disable iff (reset) (we && rd == '0) |=> $stable(regs))
    else $error("write to x0 changed register state");

endmodule

// File: datapath/alu.sv
`timescale 1ns/1ps

module alu (
  input  rvIsaPkg::word_t    a,
  input  rvIsaPkg::word_t    b,
  input  pipeCtrlPkg::aluOp_e op,
  output rvIsaPkg::word_t    result,
  output logic               zero
);
  import rvIsaPkg::*;
  import pipeCtrlPkg::*;

  word_t      sum;
  logic       sub, overflow;
  logic [4:0] shamt;

  // Shared adder, slt subtracts too
  assign sub      = (op == aluSub) || (op == aluSlt);
  assign sum      = a + (sub ? ~b : b) + {{(xlen-1){1'b0}}, sub};
  assign overflow = (a[xlen-1] ^ sum[xlen-1]) & ~(a[xlen-1] ^ b[xlen-1] ^ sub);
  assign shamt    = b[4:0];

  always_comb begin
    case (op)
      aluAdd,
      aluSub:  result = sum;
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      aluSlt:  result = {{(xlen-1){1'b0}}, sum[xlen-1] ^ overflow};
      aluRol:  result = (shamt == '0) ? a : (a << shamt) | (a >> (xlen - int'(shamt)));
      aluRor:  result = (shamt == '0) ? a : (a >> shamt) | (a << (xlen - int'(shamt)));
      aluAndn: result = a & ~b;
      aluOrn:  result = a | ~b;
      aluXnor: result = ~(a ^ b);
      aluMin:  result = ($signed(a) < $signed(b)) ? a : b;
      aluMax:  result = ($signed(a) > $signed(b)) ? a : b;
      aluMinu: result = (a < b) ? a : b;
      aluMaxu: result = (a > b) ? a : b;
      aluAbs:  result = a[xlen-1] ? -a : a;   // Most negative stays as is
      default: result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

// File: datapath/datapath.sv
`timescale 1ns/1ps

module datapath (
  input  logic            clk,
  input  logic            reset,
  input  rvIsaPkg::word_t instr,
  input  rvIsaPkg::word_t readData,
  output rvIsaPkg::word_t pc,
  output rvIsaPkg::word_t dataAddr,
  output rvIsaPkg::word_t writeData,
  output logic            retireW,
  ctrlIf.dp               ctrl,
  hazardIf.dp             haz
);
  import rvIsaPkg::*;
  import pipeCtrlPkg::*;

  word_t pcPlus4F, pcNextF;
  word_t instrD, pcD, pcPlus4D, rd1D, rd2D, immExtD;
  word_t rd1E, rd2E, pcE, pcPlus4E, immExtE;
  word_t srcAE, srcBE, writeDataE, aluResultE, pcTargetE;
  word_t aluResultM, writeDataM, pcPlus4M;
  word_t aluResultW, readDataW, pcPlus4W, resultW;
  logic  validD, validE, validM, validW;

  assign pcPlus4F = pc + 32'd4;
  assign pcNextF  = haz.pcSrcE ? pcTargetE : pcPlus4F;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) pc <= '0;
    else if (!haz.stallF) pc <= pcNextF;
  end

  // Decode register, a cleared instruction decodes as a bubble
  always_ff @(posedge clk or posedge reset) begin
    if (reset || haz.flushD) begin
      instrD <= '0;
      validD <= 1'b0;
    end else if (!haz.stallD) begin
      instrD <= instr;
      validD <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!haz.stallD) begin
      pcD      <= pc;
      pcPlus4D <= pcPlus4F;
    end
  end

  assign ctrl.instrD = instrD;
  assign haz.rs1D    = instrD[19:15];
  assign haz.rs2D    = instrD[24:20];

  regFile i_regFile (
    .clk  (clk),
    .reset(reset),
    .rs1  (haz.rs1D),
    .rs2  (haz.rs2D),
    .rd   (haz.rdW),
    .we   (ctrl.regWriteW),
    .wd   (resultW),
    .rd1  (rd1D),
    .rd2  (rd2D)
  );

  always_comb begin
    case (ctrl.immSrcD)
      immI:    immExtD = {{20{instrD[31]}}, instrD[31:20]};
      immS:    immExtD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
      immB:    immExtD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
      default: immExtD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
    endcase
  end

  // Register indices and valid bits of the later stages
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      {haz.rs1E, haz.rs2E, haz.rdE, validE} <= '0;
      {haz.rdM, validM, haz.rdW, validW}    <= '0;
    end else begin
      if (haz.flushE) begin
        {haz.rs1E, haz.rs2E, haz.rdE, validE} <= '0;
      end else begin
        haz.rs1E <= haz.rs1D;
        haz.rs2E <= haz.rs2D;
        haz.rdE  <= instrD[11:7];
        validE   <= validD;
      end
      haz.rdM <= haz.rdE;
      validM  <= validE;
      haz.rdW <= haz.rdM;
      validW  <= validM;
    end
  end

  always_ff @(posedge clk) begin
    rd1E       <= rd1D;
    rd2E       <= rd2D;
    pcE        <= pcD;
    pcPlus4E   <= pcPlus4D;
    immExtE    <= immExtD;
    aluResultM <= aluResultE;
    writeDataM <= writeDataE;
    pcPlus4M   <= pcPlus4E;
    aluResultW <= aluResultM;
    readDataW  <= readData;
    pcPlus4W   <= pcPlus4M;
  end

  // Forwarding muxes
  always_comb begin
    case (haz.forwardA)
      fwdMem:  srcAE = aluResultM;
      fwdWb:   srcAE = resultW;
      default: srcAE = rd1E;
    endcase
    case (haz.forwardB)
      fwdMem:  writeDataE = aluResultM;
      fwdWb:   writeDataE = resultW;
      default: writeDataE = rd2E;
    endcase
  end

  assign srcBE     = ctrl.aluSrcE ? immExtE : writeDataE;
  assign pcTargetE = pcE + immExtE;

  alu i_alu (
    .a     (srcAE),
    .b     (srcBE),
    .op    (ctrl.aluOpE),
    .result(aluResultE),
    .zero  (ctrl.zeroE)
  );

  assign dataAddr  = aluResultM;
  assign writeData = writeDataM;

  always_comb begin
    case (ctrl.resultSelW)
      resMem:     resultW = readDataW;
      resPcPlus4: resultW = pcPlus4W;   // jal link
      default:    resultW = aluResultW;
    endcase
  end

  assign retireW = validW;

endmodule

// File: src/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
  hazardIf.haz haz
);
  import rvIsaPkg::*;
  import pipeCtrlPkg::*;

  logic lwStall;

  // Newest producer wins, x0 is never forwarded
  function automatic fwdSel_e pickFwd(regAddr_t rs);
    if (rs != '0 && rs == haz.rdM && haz.regWriteM) return fwdMem;
    if (rs != '0 && rs == haz.rdW && haz.regWriteW) return fwdWb;
    return fwdNone;
  endfunction

  assign haz.forwardA = pickFwd(haz.rs1E);
  assign haz.forwardB = pickFwd(haz.rs2E);

  // Load result is not ready for the next instruction
  assign lwStall = haz.loadE && (haz.rs1D == haz.rdE || haz.rs2D == haz.rdE);

  assign haz.stallF = lwStall;
  assign haz.stallD = lwStall;
  assign haz.flushD = haz.pcSrcE;
  assign haz.flushE = lwStall | haz.pcSrcE;

  // The bubble clears the load from execute, so a stall lasts one cycle
  assert property (@(posedge haz.clk) disable iff (haz.reset)
    haz.stallD |-> haz.flushE ##1 !haz.stallD)
    else $error("load-use stall without bubble or longer than one cycle");

endmodule

// File: src/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
  input  logic  clk,
  input  logic  reset,
  ctrlIf.ctrl   ctrl,
  hazardIf.ctrl haz,
  output logic  memWrite
);
  import rvIsaPkg::*;
  import pipeCtrlPkg::*;

  opcode_e    opD;
  logic [2:0] funct3D;
  logic [6:0] funct7D;
  aluOp_e     aluOpD;
  logic       aluOk;     // funct fields name a known operation
  ctrlWord_t  ctrlD, ctrlE, ctrlM, ctrlW;

  assign opD     = opcode_e'(ctrl.instrD[6:0]);
  assign funct3D = ctrl.instrD[14:12];
  assign funct7D = ctrl.instrD[31:25];

  // ALU decoder
  always_comb begin
    aluOk  = 1'b1;
    aluOpD = aluAdd;
    if (opD == opCustom0) begin
      case ({funct7D, funct3D})
        {f7Logic, f3Andn}:  aluOpD = aluAndn;
        {f7Logic, f3Orn}:   aluOpD = aluOrn;
        {f7Logic, f3Xnor}:  aluOpD = aluXnor;
        {f7MinMax, f3Min}:  aluOpD = aluMin;
        {f7MinMax, f3Max}:  aluOpD = aluMax;
        {f7MinMax, f3Minu}: aluOpD = aluMinu;
        {f7MinMax, f3Maxu}: aluOpD = aluMaxu;
        {f7Rotate, f3Rol}:  aluOpD = aluRol;
        {f7Rotate, f3Ror}:  aluOpD = aluRor;
        {f7Abs, f3Abs}:     aluOpD = aluAbs;
        default:            aluOk  = 1'b0;
      endcase
    end else begin
      case (funct3D)
        f3AddSub: aluOpD = (opD == opRtype && funct7D[5]) ? aluSub : aluAdd;
        f3Slt:    aluOpD = aluSlt;
        f3Or:     aluOpD = aluOr;
        f3And:    aluOpD = aluAnd;
        default:  aluOk  = 1'b0;
      endcase
    end
  end

  // Main decoder
  always_comb begin
    ctrlD        = '0;
    ctrl.immSrcD = immI;
    case (opD)
      opLoad: if (funct3D == f3Word) begin
        ctrlD.regWrite  = 1'b1;
        ctrlD.resultSel = resMem;
        ctrlD.aluSrc    = 1'b1;
      end
      opStore: if (funct3D == f3Word) begin
        ctrlD.memWrite = 1'b1;
        ctrlD.aluSrc   = 1'b1;
        ctrl.immSrcD   = immS;
      end
      opRtype, opCustom0, opItype: if (aluOk) begin
        ctrlD.regWrite = 1'b1;
        ctrlD.aluOp    = aluOpD;
        ctrlD.aluSrc   = (opD == opItype);
      end
      opBranch: if (funct3D == f3Beq) begin
        ctrlD.branch = 1'b1;
        ctrlD.aluOp  = aluSub;   // Equal when the difference is zero
        ctrl.immSrcD = immB;
      end
      opJal: begin
        ctrlD.regWrite  = 1'b1;
        ctrlD.jump      = 1'b1;
        ctrlD.resultSel = resPcPlus4;
        ctrl.immSrcD    = immJ;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ctrlE <= '0;
      ctrlM <= '0;
      ctrlW <= '0;
    end else begin
      ctrlE <= haz.flushE ? '0 : ctrlD;
      ctrlM <= ctrlE;
      ctrlW <= ctrlM;
    end
  end

  assign ctrl.aluOpE     = ctrlE.aluOp;
  assign ctrl.aluSrcE    = ctrlE.aluSrc;
  assign haz.loadE       = (ctrlE.resultSel == resMem);
  assign haz.pcSrcE      = (ctrlE.branch & ctrl.zeroE) | ctrlE.jump;
  assign haz.regWriteM   = ctrlM.regWrite;
  assign memWrite        = ctrlM.memWrite;
  assign haz.regWriteW   = ctrlW.regWrite;
  assign ctrl.regWriteW  = ctrlW.regWrite;
  assign ctrl.resultSelW = ctrlW.resultSel;

  // A store never also writes a register
  assert property (@(posedge clk) disable iff (reset) !(ctrlM.memWrite && ctrlM.regWrite))
    else $error("store and register write together in memory stage");

endmodule

// File: src/riscvCore.sv
`timescale 1ns/1ps

module riscvCore (
  input  logic            clk,
  input  logic            reset,
  input  rvIsaPkg::word_t instr,
  input  rvIsaPkg::word_t readData,
  output rvIsaPkg::word_t pc,
  output logic            memWrite,
  output rvIsaPkg::word_t dataAddr,
  output rvIsaPkg::word_t writeData,
  output rvIsaPkg::word_t cycleCount,
  output rvIsaPkg::word_t instrRetired
);

  logic retireW;

  ctrlIf   ctrlBus ();
  hazardIf hazBus (.clk(clk), .reset(reset));

  controlUnit i_controlUnit (
    .clk     (clk),
    .reset   (reset),
    .ctrl    (ctrlBus.ctrl),
    .haz     (hazBus.ctrl),
    .memWrite(memWrite)
  );

  datapath i_datapath (
    .clk      (clk),
    .reset    (reset),
    .instr    (instr),
    .readData (readData),
    .pc       (pc),
    .dataAddr (dataAddr),
    .writeData(writeData),
    .retireW  (retireW),
    .ctrl     (ctrlBus.dp),
    .haz      (hazBus.dp)
  );

  hazardUnit i_hazardUnit (
    .haz(hazBus.haz)
  );

  // Performance counters, bubbles never reach retireW
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cycleCount   <= '0;
      instrRetired <= '0;
    end else begin
      cycleCount <= cycleCount + 1'b1;
      if (retireW) instrRetired <= instrRetired + 1'b1;
    end
  end

endmodule

// File: testbench/tbClock.sv
`timescale 1ns/1ps

module tbClock (
  output logic clk,
  output logic reset
);
  localparam int resetCycles = 4;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;   // 4 ns period
  end

  // Released on a falling edge, away from the sampling edge
  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(negedge clk);
    reset <= 1'b0;
  end
endmodule

// File: testbench/tbRiscvCore.sv
`timescale 1ns/1ps

module tbRiscvCore;
  import rvIsaPkg::*;

  typedef enum {kAdd, kSub, kAnd, kOr, kSlt, kAndn, kOrn, kXnor, kMin, kMax,
                kMinu, kMaxu, kRol, kRor, kAbs} opKind_e;

  localparam int    timeoutCycles = 400;   // About five times the program path
  localparam int    poisonWord    = 62;
  localparam int    doneWord      = 63;
  localparam word_t poisonAddr    = 32'd248;
  localparam word_t doneAddr      = 32'd252;

  logic       clk, reset, memWrite, storeOk;
  word_t      instr, readData, pc, dataAddr, writeData, cycleCount, instrRetired;
  word_t      imem [128];
  word_t      dram [64];
  word_t      ramInit [64];
  word_t      expData [64];
  logic       expValid [64];
  word_t      model [32];   // Architectural register values
  logic [5:0] storeIdx;
  int         progLen, pathCount, expRetired, nextWord;
  int         cycles = 0;
  integer     seed;

  tbClock i_tbClock (.clk(clk), .reset(reset));

  riscvCore i_riscvCore (
    .clk         (clk),
    .reset       (reset),
    .instr       (instr),
    .readData    (readData),
    .pc          (pc),
    .memWrite    (memWrite),
    .dataAddr    (dataAddr),
    .writeData   (writeData),
    .cycleCount  (cycleCount),
    .instrRetired(instrRetired)
  );

  function automatic word_t rType(logic [6:0] f7, regAddr_t rs2, regAddr_t rs1,
                                  logic [2:0] f3, regAddr_t rd, opcode_e op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic word_t iType(logic [11:0] imm, regAddr_t rs1, logic [2:0] f3,
                                  regAddr_t rd, opcode_e op);
    return {imm, rs1, f3, rd, op};
  endfunction

  // Stores always use x0 as base
  function automatic word_t sType(logic [11:0] imm, regAddr_t rs2);
    return {imm[11:5], rs2, 5'd0, f3Word, imm[4:0], opStore};
  endfunction

  function automatic word_t bType(logic [12:0] imm, regAddr_t rs2, regAddr_t rs1);
    return {imm[12], imm[10:5], rs2, rs1, f3Beq, imm[4:1], imm[11], opBranch};
  endfunction

  function automatic word_t jType(logic [20:0] imm, regAddr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
  endfunction

  function automatic word_t encodeOp(opKind_e kind, regAddr_t rd, regAddr_t rs1, regAddr_t rs2);
    case (kind)
      kAdd:    return rType(7'b0000000, rs2, rs1, f3AddSub, rd, opRtype);
      kSub:    return rType(7'b0100000, rs2, rs1, f3AddSub, rd, opRtype);
      kAnd:    return rType(7'b0000000, rs2, rs1, f3And, rd, opRtype);
      kOr:     return rType(7'b0000000, rs2, rs1, f3Or, rd, opRtype);
      kSlt:    return rType(7'b0000000, rs2, rs1, f3Slt, rd, opRtype);
      kAndn:   return rType(f7Logic, rs2, rs1, f3Andn, rd, opCustom0);
      kOrn:    return rType(f7Logic, rs2, rs1, f3Orn, rd, opCustom0);
      kXnor:   return rType(f7Logic, rs2, rs1, f3Xnor, rd, opCustom0);
      kMin:    return rType(f7MinMax, rs2, rs1, f3Min, rd, opCustom0);
      kMax:    return rType(f7MinMax, rs2, rs1, f3Max, rd, opCustom0);
      kMinu:   return rType(f7MinMax, rs2, rs1, f3Minu, rd, opCustom0);
      kMaxu:   return rType(f7MinMax, rs2, rs1, f3Maxu, rd, opCustom0);
      kRol:    return rType(f7Rotate, rs2, rs1, f3Rol, rd, opCustom0);
      kRor:    return rType(f7Rotate, rs2, rs1, f3Ror, rd, opCustom0);
      default: return rType(f7Abs, 5'd0, rs1, f3Abs, rd, opCustom0);
    endcase
  endfunction

  function automatic word_t encodeImm(opKind_e kind, regAddr_t rd, regAddr_t rs1,
                                      logic [11:0] imm);
    case (kind)
      kAnd:    return iType(imm, rs1, f3And, rd, opItype);
      kOr:     return iType(imm, rs1, f3Or, rd, opItype);
      kSlt:    return iType(imm, rs1, f3Slt, rd, opItype);
      default: return iType(imm, rs1, f3AddSub, rd, opItype);
    endcase
  endfunction

  function automatic word_t rotateLeft(word_t a, logic [4:0] sh);
    logic [63:0] twice;
    twice = {a, a} << sh;
    return twice[63:32];
  endfunction

  function automatic word_t rotateRight(word_t a, logic [4:0] sh);
    logic [63:0] twice;
    twice = {a, a} >> sh;
    return twice[31:0];
  endfunction

  function automatic word_t expectedResult(opKind_e kind, word_t a, word_t b);
    case (kind)
      kAdd:    return a + b;
      kSub:    return a - b;
      kAnd:    return a & b;
      kOr:     return a | b;
      kSlt:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      kAndn:   return a & ~b;
      kOrn:    return a | ~b;
      kXnor:   return a ~^ b;
      kMin:    return ($signed(a) <= $signed(b)) ? a : b;
      kMax:    return ($signed(a) >= $signed(b)) ? a : b;
      kMinu:   return (a <= b) ? a : b;
      kMaxu:   return (a >= b) ? a : b;
      kRol:    return rotateLeft(a, b[4:0]);
      kRor:    return rotateRight(a, b[4:0]);
      default: return a[31] ? (~a + 32'd1) : a;
    endcase
  endfunction

  task automatic emit(input word_t word, input logic onPath);
    imem[progLen] = word;
    progLen++;
    if (onPath) pathCount++;   // Skipped instructions never retire
  endtask

  task automatic storeResult(input regAddr_t rs, input int word);
    emit(sType(12'(word * 4), rs), 1'b1);
    expData[word]  = model[rs];
    expValid[word] = 1'b1;
  endtask

  task automatic storeNext(input regAddr_t rs);
    storeResult(rs, nextWord);
    nextWord++;
  endtask

  task automatic computeOp(input opKind_e kind, input regAddr_t rd, input regAddr_t rs1,
                           input regAddr_t rs2);
    emit(encodeOp(kind, rd, rs1, rs2), 1'b1);
    model[rd] = expectedResult(kind, model[rs1], model[rs2]);
  endtask

  task automatic runOp(input opKind_e kind, input regAddr_t rd, input regAddr_t rs1,
                       input regAddr_t rs2);
    computeOp(kind, rd, rs1, rs2);
    storeNext(rd);
  endtask

  task automatic runImm(input opKind_e kind, input regAddr_t rd, input regAddr_t rs1);
    logic [11:0] imm;
    imm = 12'($random(seed));
    emit(encodeImm(kind, rd, rs1, imm), 1'b1);
    model[rd] = expectedResult(kind, model[rs1], {{20{imm[11]}}, imm});
    storeNext(rd);
  endtask

  task automatic loadWord(input regAddr_t rd, input int word);
    emit(iType(12'(word * 4), 5'd0, f3Word, rd, opLoad), 1'b1);
    model[rd] = ramInit[word];
  endtask

  task automatic setReg(input regAddr_t rd, input logic [11:0] imm);
    emit(iType(imm, 5'd0, f3AddSub, rd, opItype), 1'b1);
    model[rd] = {{20{imm[11]}}, imm};
  endtask

  task automatic buildProgram();
    int jalPc;
    seed = 32'h2e3d;
    for (int i = 0; i < 128; i++) imem[i] = iType(12'(i), 5'd0, f3AddSub, 5'd0, opItype);
    for (int i = 0; i < 64; i++) begin
      ramInit[i]  = {16'h5a5a, 10'd0, 6'(i)};
      expValid[i] = 1'b0;
    end
    for (int i = 0; i < 5; i++) ramInit[i] = $random(seed);
    ramInit[3] = ramInit[3] | 32'h8000_0000;   // Negative operand for abs
    for (int i = 0; i < 32; i++) model[i] = '0;
    progLen   = 0;
    pathCount = 0;
    nextWord  = 16;
    loadWord(5'd1, 0);
    loadWord(5'd2, 1);
    loadWord(5'd3, 2);
    loadWord(5'd7, 3);
    setReg(5'd5, 12'd0);    // Rotate by zero
    setReg(5'd6, 12'd31);
    // Dependent chain, sources come from memory and writeback
    computeOp(kAdd, 5'd8, 5'd1, 5'd2);
    runOp(kSub, 5'd9, 5'd8, 5'd3);      // rs1 from memory
    storeNext(5'd8);
    computeOp(kAnd, 5'd10, 5'd9, 5'd1);
    runOp(kOr, 5'd11, 5'd2, 5'd10);     // rs2 from memory
    runOp(kSlt, 5'd12, 5'd3, 5'd11);    // rs2 from writeback
    runImm(kAdd, 5'd13, 5'd12);         // rs1 from writeback
    runImm(kAnd, 5'd14, 5'd13);
    runImm(kOr, 5'd15, 5'd14);
    runImm(kSlt, 5'd16, 5'd15);
    storeNext(5'd10);
    runOp(kAndn, 5'd24, 5'd1, 5'd2);
    runOp(kOrn, 5'd24, 5'd1, 5'd2);
    runOp(kXnor, 5'd24, 5'd1, 5'd3);
    runOp(kMin, 5'd24, 5'd7, 5'd1);
    runOp(kMax, 5'd24, 5'd7, 5'd2);
    runOp(kMinu, 5'd24, 5'd7, 5'd1);
    runOp(kMaxu, 5'd24, 5'd7, 5'd2);
    runOp(kRol, 5'd24, 5'd1, 5'd2);
    runOp(kRol, 5'd24, 5'd1, 5'd5);
    runOp(kRol, 5'd24, 5'd1, 5'd6);
    runOp(kRor, 5'd24, 5'd3, 5'd2);
    runOp(kRor, 5'd24, 5'd3, 5'd5);
    runOp(kRor, 5'd24, 5'd3, 5'd6);
    runOp(kAbs, 5'd24, 5'd7, 5'd0);
    runOp(kAbs, 5'd24, 5'd2, 5'd0);
    loadWord(5'd20, 4);
    runOp(kAdd, 5'd21, 5'd20, 5'd2);   // Load-use, one stall
    emit(bType(13'd8, 5'd1, 5'd1), 1'b1);   // Taken
    emit(sType(12'(poisonWord * 4), 5'd1), 1'b0);
    emit(bType(13'd8, 5'd6, 5'd5), 1'b1);   // Not taken
    storeNext(5'd6);
    jalPc = progLen * 4;
    emit(jType(21'd8, 5'd22), 1'b1);
    emit(sType(12'(poisonWord * 4), 5'd1), 1'b0);
    model[22] = jalPc + 4;
    storeNext(5'd22);
    storeResult(5'd1, doneWord);
    expRetired = pathCount;
    emit(jType(21'd0, 5'd0), 1'b0);   // Park here
  endtask

  task automatic failRun(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on failure");
  endtask

  task automatic valueError(input string msg);
    failRun($sformatf("[ERROR] %0t ns: %s", $time, msg));
  endtask

  initial begin
    instr = '0;
    forever @(negedge clk) instr <= imem[pc[8:2]];
  end

  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 64; i++) dram[i] <= ramInit[i];
    end else if (memWrite) begin
      dram[dataAddr[7:2]] <= writeData;
    end
  end

  assign readData = dram[dataAddr[7:2]];
  assign storeIdx = dataAddr[7:2];
  assign storeOk  = (dataAddr[31:8] == '0) && (dataAddr[1:0] == '0) &&
                    expValid[storeIdx] && (writeData == expData[storeIdx]);

  always @(posedge clk) begin
    if (cycles >= timeoutCycles) failRun("Timeout: the program never reached its done store");
    else cycles <= cycles + 1;
  end

  // Reset state, through the first cycle after release
  assert property (@(posedge clk) $past(reset) |->
    (pc == '0 && !memWrite && cycleCount == '0 && instrRetired == '0))
    else valueError("core state not cleared by reset");

  assert property (@(posedge clk) disable iff (reset)
    !$past(reset) |-> cycleCount == $past(cycleCount) + 32'd1)
    else valueError("cycleCount did not advance by one");

  assert property (@(posedge clk) disable iff (reset) memWrite |-> storeOk)
    else valueError("store address or data differs from the expected table");

  assert property (@(posedge clk) disable iff (reset) memWrite |-> dataAddr != poisonAddr)
    else valueError("store reached the poison address");

  assert property (@(posedge clk) disable iff (reset)
    $past(memWrite && dataAddr == doneAddr, 2) |-> instrRetired == expRetired)
    else valueError($sformatf("instrRetired is not the %0d path instructions", expRetired));

  initial begin
    buildProgram();
    @(negedge clk);
    while (!(memWrite && dataAddr == doneAddr)) @(negedge clk);
    repeat (3) @(negedge clk);   // Retire check is sampled two edges after the store
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: riscvCore.f
common/rvIsaPkg.sv
common/pipeCtrlPkg.sv
common/ctrlIf.sv
common/hazardIf.sv
datapath/regFile.sv
datapath/alu.sv
datapath/datapath.sv
src/hazardUnit.sv
src/controlUnit.sv
src/riscvCore.sv
testbench/tbClock.sv
testbench/tbRiscvCore.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
  --top-module tbRiscvCore -f riscvCore.f -o simRiscvCore
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

simOutput=$(./obj_dir/simRiscvCore)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOutput" | grep -qx "RESULT: PASS"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
